// File: verilog/dsp_ctrl_pkg.sv
// Types and constants shared by the DSP instruction-decode controller.
// Only the kept instruction groups have T codes here. Every other T code decodes as illegal.
// The control word is about 40 bits and is cleared in every cycle that has no accepted word.
package dsp_ctrl_pkg;

    // Instruction field positions
    localparam int T_MSB  = 15;
    localparam int T_LSB  = 11;
    localparam int NI_MSB = 10;
    localparam int NI_LSB = 7;
    localparam int K_MSB  = 6;
    localparam int K_LSB  = 0;

    localparam int NI_W = NI_MSB - NI_LSB + 1;  // Loop body length
    localparam int K_W  = K_MSB - K_LSB + 1;    // Loop repeat count

    // T field group codes
    localparam logic [4:0] T_GOTO_JA   = 5'b00000;
    localparam logic [4:0] T_CALL_JA   = 5'b10000;
    localparam logic [4:0] T_GOTO_B    = 5'b11000;
    localparam logic [4:0] T_SHORT_IMM = 5'b00010;  // Also 00011, bit 11 is a register bit
    localparam logic [4:0] T_LONG_IMM  = 5'b01010;
    localparam logic [4:0] T_R_FROM_A0 = 5'b01001;
    localparam logic [4:0] T_R_FROM_A1 = 5'b01011;
    localparam logic [4:0] T_R_FROM_Y  = 5'b01111;
    localparam logic [4:0] T_Y_FROM_R  = 5'b01100;
    localparam logic [4:0] T_F1_Y      = 5'b00110;
    localparam logic [4:0] T_F1_AT_Y   = 5'b00111;
    localparam logic [4:0] T_F1_X_Y    = 5'b10110;
    localparam logic [4:0] T_COND      = 5'b11010;
    localparam logic [4:0] T_DO        = 5'b01110;

    // Y pointer increment select
    localparam logic [1:0] INC_DOWN = 2'd0;
    localparam logic [1:0] INC_HOLD = 2'd1;
    localparam logic [1:0] INC_UP   = 2'd2;

    typedef logic [15:0] instr_word_t;

    typedef struct packed {
        logic       post_load;   // Write back the modified pointer
        logic [1:0] inc_sel;
        logic       step_sel;    // Step by j instead of inc_sel
        logic [1:0] y_field;     // Pointer number
    } yaau_ctrl_t;

    typedef struct packed {
        logic goto_ja;
        logic goto_b;
        logic call_ja;
        logic imm_load;
        logic acc_load;
    } xaau_ctrl_t;

    typedef struct packed {
        logic       dec_en;      // F1 operation enable
        logic       imm_load;
        logic       ram_load;
        logic       acc_load;
        logic       rmux_load;
        logic       acc_ram;
        logic       st_a0h;
        logic       st_a1h;
        logic [1:0] a_field;
    } dau_ctrl_t;

    typedef struct packed {
        yaau_ctrl_t yaau;
        xaau_ctrl_t xaau;
        dau_ctrl_t  dau;
        logic       short_load;
        logic       long_load;
        logic       ram_we;
        logic [2:0] r_field;
        logic [2:0] rsel;
        logic [8:0] short_imm;
        logic       is_double;   // The datapath needs a second cycle
    } ctrl_word_t;

    typedef struct packed {
        logic            busy;
        logic            first_pass;  // Last instruction of the first pass
        logic            last_instr;  // Last instruction of the whole loop
        logic [NI_W-1:0] idx;
    } loop_status_t;

endpackage

// File: verilog/issue_seq.sv
// Input handshake with the two-cycle rule.
// instr_ready drops in the cycle that shows a two-cycle control word or a loop boundary.
// The drop lasts one cycle, so the datapath gets its second cycle.
module issue_seq (
    input  logic clk,
    input  logic rst,
    input  logic instr_valid,
    output logic instr_ready,
    output logic accept,
    input  logic double_now,
    input  logic loop_hold
);

    logic hold_req;
    logic hold_q;    // A hold cycle was just spent

    // Both requests are registered pulses that come with ctrl_valid
    assign hold_req = double_now | loop_hold;

    assign instr_ready = ~(hold_req & ~hold_q);
    assign accept      = instr_valid & instr_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= ~instr_ready;
        end
    end

    // Nothing enters while the datapath finishes a word
    a_no_accept_in_hold: assert property (@(posedge clk) disable iff (rst)
        hold_req |-> !accept)
        else $error("word accepted in the cycle of a hold request");

    // No word is accepted in the hold cycle, so no new request can follow it.
    // A second request here would be lost.
    a_single_hold: assert property (@(posedge clk) disable iff (rst)
        !instr_ready |=> instr_ready && !hold_req)
        else $error("hold lasted longer than one cycle");

endmodule

// File: verilog/instr_decoder.sv
// Decodes one accepted word into a registered control word one cycle later.
// Branches take effect only when con_result is high, but they always take two cycles.
// The fault flag is sticky and is cleared only by reset.
module instr_decoder
    import dsp_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            accept,
    input  instr_word_t     instr,
    input  logic            con_result,
    input  logic            loop_busy,
    output ctrl_word_t      ctrl,
    output logic            ctrl_valid,
    output logic            do_load,
    output logic [NI_W-1:0] do_ni,
    output logic [K_W-1:0]  do_k,
    output logic            fault
);

    logic [4:0]      t_code;
    logic [NI_W-1:0] ni_field;
    yaau_ctrl_t      y_mode;
    ctrl_word_t      ctrl_d;
    logic            illegal;

    assign t_code   = instr[T_MSB:T_LSB];
    assign ni_field = instr[NI_MSB:NI_LSB];

    // The loop counter loads on the same edge that accepts the DO word
    assign do_load = accept && (t_code == T_DO);
    assign do_ni   = ni_field - 1'b1;  // NI of 0 wraps to a 16 word body
    assign do_k    = instr[K_MSB:K_LSB];

    // Pointer post-modify, the same for every Y group
    always_comb begin
        y_mode           = '0;
        y_mode.post_load = 1'b1;
        y_mode.y_field   = instr[3:2];
        case (instr[1:0])
            2'd0:    y_mode.inc_sel  = INC_HOLD;  // *rN
            2'd1:    y_mode.inc_sel  = INC_UP;    // *rN++
            2'd2:    y_mode.inc_sel  = INC_DOWN;  // *rN--
            default: y_mode.step_sel = 1'b1;      // *rN++j
        endcase
    end

    always_comb begin
        ctrl_d  = '0;
        illegal = 1'b0;
        if (accept) begin
            case (t_code)
                T_GOTO_JA: begin
                    ctrl_d.xaau.goto_ja = con_result;
                    ctrl_d.is_double    = 1'b1;
                    illegal             = loop_busy;  // No branching out of a DO body
                end
                T_CALL_JA: begin
                    ctrl_d.xaau.call_ja = con_result;
                    ctrl_d.is_double    = 1'b1;
                    illegal             = loop_busy;
                end
                T_GOTO_B: begin
                    ctrl_d.xaau.goto_b = con_result;
                    ctrl_d.is_double   = 1'b1;
                    illegal            = loop_busy;
                end
                T_SHORT_IMM, T_SHORT_IMM + 5'd1: begin
                    ctrl_d.short_load = 1'b1;
                    ctrl_d.r_field    = instr[11:9] ^ 3'b100;
                    ctrl_d.short_imm  = instr[8:0];
                end
                T_LONG_IMM: begin
                    // Destination group in bits 9:7, the immediate follows
                    ctrl_d.long_load     = instr[9:7] == 3'b000;
                    ctrl_d.xaau.imm_load = instr[9:7] == 3'b001;
                    ctrl_d.dau.imm_load  = instr[9:7] == 3'b010;
                    ctrl_d.r_field       = instr[6:4];
                    ctrl_d.is_double     = 1'b1;
                    illegal              = loop_busy;
                end
                T_R_FROM_A0, T_R_FROM_A1: begin
                    ctrl_d.r_field       = instr[6:4];
                    ctrl_d.dau.a_field   = {1'b1, instr[12]};  // a0 or a1
                    ctrl_d.dau.acc_load  = instr[8:7] == 2'b10;
                    ctrl_d.xaau.acc_load = instr[8:7] == 2'b01;
                    ctrl_d.is_double     = 1'b1;
                end
                T_R_FROM_Y, T_Y_FROM_R: begin
                    ctrl_d.yaau      = y_mode;
                    ctrl_d.rsel      = instr[8:6];
                    ctrl_d.r_field   = instr[6:4];
                    ctrl_d.is_double = 1'b1;
                    if (t_code == T_Y_FROM_R) begin
                        ctrl_d.ram_we        = 1'b1;
                        ctrl_d.dau.rmux_load = 1'b1;  // Register mux drives RAM
                    end else begin
                        ctrl_d.dau.ram_load = instr[9:7] == 3'b010;
                    end
                end
                T_F1_Y, T_F1_AT_Y: begin
                    ctrl_d.dau.dec_en  = 1'b1;
                    ctrl_d.dau.a_field = instr[10:9];
                    ctrl_d.yaau        = y_mode;
                    if (instr[11]) begin
                        // Accumulator high half goes to RAM
                        ctrl_d.dau.st_a1h  = ~instr[10];
                        ctrl_d.dau.st_a0h  = instr[10];
                        ctrl_d.dau.acc_ram = 1'b1;
                    end
                end
                T_F1_X_Y: begin
                    ctrl_d.dau.dec_en   = 1'b1;
                    ctrl_d.dau.ram_load = 1'b1;
                    ctrl_d.r_field      = 3'd0;  // x register
                    ctrl_d.yaau         = y_mode;
                end
                T_COND, T_DO: begin
                    // No datapath strobes, DO goes to the loop counter
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl       <= '0;
            ctrl_valid <= 1'b0;
            fault      <= 1'b0;
        end else begin
            ctrl       <= ctrl_d;        // All zero when nothing is accepted
            ctrl_valid <= accept;
            fault      <= fault | illegal;
        end
    end

    // The ROM pointer can follow only one branch per word
    a_one_branch: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctrl.xaau.goto_ja, ctrl.xaau.goto_b, ctrl.xaau.call_ja}))
        else $error("more than one xaau branch strobe");

endmodule

// File: verilog/do_loop_ctr.sv
// Hardware DO loop counters, advanced once for each accepted word while busy.
// Status is registered on the accept edge and lines up with the control word.
// A DO with K of 0 does not start a loop. Nested DO is not supported.
module do_loop_ctr
    import dsp_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            accept,
    input  logic            do_load,
    input  logic [NI_W-1:0] do_ni,
    input  logic [K_W-1:0]  do_k,
    output loop_status_t    loop,
    output logic            loop_hold
);

    logic [NI_W-1:0] pos;       // Position of the next body word
    logic [NI_W-1:0] ni_max;    // NI minus 1
    logic [K_W-1:0]  k_left;    // Passes still to run, including this one
    logic            in_first;
    logic            wrap;

    assign wrap      = pos == ni_max;
    assign loop_hold = loop.first_pass | loop.last_instr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos      <= '0;
            ni_max   <= '0;
            k_left   <= '0;
            in_first <= 1'b0;
            loop     <= '0;
        end else begin
            // Boundary markers are one-cycle pulses
            loop.first_pass <= 1'b0;
            loop.last_instr <= 1'b0;
            if (loop.last_instr) begin
                loop.busy <= 1'b0;  // Drops after the final hold cycle
            end

            if (do_load) begin
                ni_max    <= do_ni;
                k_left    <= do_k;
                pos       <= '0;
                in_first  <= 1'b1;
                loop.busy <= do_k != '0;
                loop.idx  <= '0;
            end else if (accept && loop.busy) begin
                loop.idx        <= pos;
                loop.first_pass <= wrap & in_first;
                loop.last_instr <= wrap & (k_left == K_W'(1));
                if (wrap) begin
                    pos      <= '0;
                    in_first <= 1'b0;
                    if (k_left != '0) begin
                        k_left <= k_left - 1'b1;  // Stops at zero
                    end
                end else begin
                    pos <= pos + 1'b1;
                end
            end else if (accept) begin
                loop.idx <= '0;     // Outside any loop
            end
        end
    end

    // A DO inside a running body would overwrite the live counts
    a_no_nested_do: assert property (@(posedge clk) disable iff (rst)
        do_load |-> !loop.busy)
        else $error("DO loaded while a loop is busy");

endmodule

// File: verilog/dsp_ctrl.sv
// Instruction-decode controller for the 16-bit DSP core.
// The source must keep instr and con_result stable until the word is accepted.
// One control word per accepted instruction. The output side cannot stall.
module dsp_ctrl
    import dsp_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  instr_word_t  instr,
    input  logic         con_result,
    input  logic         instr_valid,
    output logic         instr_ready,
    output ctrl_word_t   ctrl,
    output logic         ctrl_valid,
    output loop_status_t loop,
    output logic         fault
);

    logic            accept;
    logic            loop_hold;   // Loop boundary, costs one fetch cycle
    logic            do_load;
    logic [NI_W-1:0] do_ni;
    logic [K_W-1:0]  do_k;

    issue_seq u_issue_seq (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .accept      (accept),
        .double_now  (ctrl.is_double),  // Only high while ctrl_valid
        .loop_hold   (loop_hold)
    );

    instr_decoder u_instr_decoder (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .instr      (instr),
        .con_result (con_result),
        .loop_busy  (loop.busy),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid),
        .do_load    (do_load),
        .do_ni      (do_ni),
        .do_k       (do_k),
        .fault      (fault)
    );

    do_loop_ctr u_do_loop_ctr (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .do_load   (do_load),
        .do_ni     (do_ni),
        .do_k      (do_k),
        .loop      (loop),
        .loop_hold (loop_hold)
    );

endmodule

// File: verif/dsp_ctrl_checker.sv
// Compares the DUT ports with the expected records, in order of ctrl_valid.
// Outputs are sampled on the falling edge, where they are stable.
// Counts instr_ready low cycles against the expected holds at the end of the run.
module dsp_ctrl_checker
    import dsp_ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         instr_ready,
    input ctrl_word_t   ctrl,
    input logic         ctrl_valid,
    input loop_status_t loop,
    input logic         fault
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [15:0]     test;
        logic [2:0]      brn;    // goto_ja, goto_b, call_ja
        logic [12:0]     lds;
        logic [5:0]      ymode;
        logic [2:0]      rf;
        logic [2:0]      rs;
        logic            dbl;
        logic [NI_W-1:0] idx;
        logic            fp;
        logic            li;
        logic            flt;
    } expect_t;

    expect_t exp_q [$];
    int      checked        = 0;
    int      errors         = 0;
    int      tests_failed   = 0;
    int      low_cycles     = 0;
    int      holds_expected = 0;
    int      mism           = 0;
    logic    reset_seen     = 1'b0;

    task automatic add_expected(input int t, input logic [2:0] brn, input logic [12:0] lds,
                                input logic [5:0] ym, input logic [2:0] rf,
                                input logic [2:0] rs, input logic dbl,
                                input logic [NI_W-1:0] idx, input logic fp, input logic li,
                                input logic flt);
        exp_q.push_back({t[15:0], brn, lds, ym, rf, rs, dbl, idx, fp, li, flt});
    endtask

    task automatic compare_field(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED at %0t ns: %s expected %0h actual %0h",
                     $time, name, exp_v, act_v);
            mism++;
        end
    endtask

    task automatic close_test(input int t, input string what);
        $display("test %0d %s %s", t, what, (mism == 0) ? "ok" : "failed");
        if (mism != 0) begin
            errors += mism;
            tests_failed++;
        end
    endtask

    task automatic check_reset_state();
        mism = 0;
        compare_field("ctrl_valid", 0, ctrl_valid);
        compare_field("ctrl", 0, ctrl);
        compare_field("fault", 0, fault);
        compare_field("loop.busy", 0, loop.busy);
        compare_field("instr_ready", 1, instr_ready);
        close_test(0, "reset state");
    endtask

    task automatic check_record(input expect_t e);
        logic hold;
        hold = e.dbl | e.fp | e.li;  // One lost fetch cycle
        mism = 0;
        compare_field("ctrl.xaau branch strobes", e.brn,
                      {ctrl.xaau.goto_ja, ctrl.xaau.goto_b, ctrl.xaau.call_ja});
        compare_field("ctrl load strobes", e.lds,
                      {ctrl.short_load, ctrl.long_load, ctrl.xaau.imm_load,
                       ctrl.xaau.acc_load, ctrl.dau.imm_load, ctrl.dau.acc_load,
                       ctrl.dau.ram_load, ctrl.dau.rmux_load, ctrl.ram_we, ctrl.dau.dec_en,
                       ctrl.dau.acc_ram, ctrl.dau.st_a0h, ctrl.dau.st_a1h});
        compare_field("ctrl.yaau", e.ymode, ctrl.yaau);
        compare_field("ctrl.r_field", e.rf, ctrl.r_field);
        compare_field("ctrl.rsel", e.rs, ctrl.rsel);
        compare_field("ctrl.is_double", e.dbl, ctrl.is_double);
        compare_field("loop.idx", e.idx, loop.idx);
        compare_field("loop.first_pass", e.fp, loop.first_pass);
        compare_field("loop.last_instr", e.li, loop.last_instr);
        compare_field("fault", e.flt, fault);
        compare_field("instr_ready", !hold, instr_ready);
        holds_expected += hold;
        checked++;
        close_test(e.test, "control word");
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (!reset_seen) begin
                check_reset_state();
                reset_seen = 1'b1;
            end
            if (!instr_ready) begin
                low_cycles++;
            end
            if (ctrl_valid) begin
                if (exp_q.size() == 0) begin
                    $display("control word at %0t ns with no expected record left", $time);
                    errors++;
                end else begin
                    check_record(exp_q.pop_front());
                end
            end else if (ctrl !== '0) begin
                $display("CHECK FAILED at %0t ns: ctrl expected 0 actual %0h", $time, ctrl);
                errors++;
            end
        end
    end

    task automatic report();
        if (low_cycles != holds_expected) begin
            $display("instr_ready was low for %0d cycles but %0d hold cycles were expected",
                     low_cycles, holds_expected);
            errors++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected records were never matched", exp_q.size());
            errors++;
        end
        $display("tests %0d  passed %0d  failed %0d  errors %0d",
                 checked + 1, checked + 1 - tests_failed, tests_failed, errors);
    endtask

endmodule

// File: verif/dsp_ctrl_tb.sv
// Testbench for the DSP instruction-decode controller.
// Stimulus and expected fields come from verif/dsp_ctrl_golden.txt, read from the project root.
// Random idle gaps of 0 to 3 cycles go between words. The checker does all comparing.
module dsp_ctrl_tb
    import dsp_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_REC        = 64;
    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_REC = 40;
    localparam int CLK_PERIOD     = 10;

    logic         clk;
    logic         rst;
    instr_word_t  instr;
    logic         con_result;
    logic         instr_valid;
    logic         instr_ready;
    ctrl_word_t   ctrl;
    logic         ctrl_valid;
    loop_status_t loop;
    logic         fault;

    instr_word_t  stim_word [MAX_REC];
    logic         stim_con [MAX_REC];
    int           n_rec;
    logic         loaded;
    int unsigned  seed;

    dsp_ctrl uut (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .con_result  (con_result),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid),
        .loop        (loop),
        .fault       (fault)
    );

    dsp_ctrl_checker dsp_ctrl_checker (
        .clk         (clk),
        .rst         (rst),
        .instr_ready (instr_ready),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid),
        .loop        (loop),
        .fault       (fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Stimulus goes to local arrays, expected fields go to the checker queue
    task automatic read_golden(output logic ok);
        reg [8*128-1:0] line;
        int             fd;
        int             cnt;
        int             t;
        logic [15:0]    w;
        logic           c;
        logic [2:0]     brn;
        logic [12:0]    lds;
        logic [5:0]     ym;
        logic [2:0]     rf;
        logic [2:0]     rs;
        logic           dbl;
        logic [3:0]     idx;
        logic           fp;
        logic           li;
        logic           flt;
        n_rec = 0;
        fd    = $fopen("verif/dsp_ctrl_golden.txt", "r");
        ok    = fd != 0;
        if (ok) begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                cnt = $fgets(line, fd);
                if (cnt > 0) begin
                    cnt = $sscanf(line, "%d %h %b %b %b %b %d %d %b %d %b %b %b",
                                  t, w, c, brn, lds, ym, rf, rs, dbl, idx, fp, li, flt);
                    if (cnt == 13) begin  // Comment and blank lines fall through
                        stim_word[n_rec] = w;
                        stim_con[n_rec]  = c;
                        dsp_ctrl_checker.add_expected(t, brn, lds, ym, rf, rs, dbl, idx,
                                                      fp, li, flt);
                        n_rec++;
                    end
                end
            end
            $fclose(fd);
            ok = n_rec > 0;
        end
    endtask

    // Entered 1 ns after a rising edge, leaves 1 ns after the accepting edge
    task automatic send_word(input instr_word_t w, input logic c);
        logic taken;
        instr       = w;
        con_result  = c;
        instr_valid = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready;  // Stable until the next rising edge
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b0;
        instr       = '0;
        con_result  = 1'b0;
    endtask

    initial begin
        logic ok;
        int   gap;
        rst         = 1'b1;
        instr       = '0;
        con_result  = 1'b0;
        instr_valid = 1'b0;
        loaded      = 1'b0;
        seed        = 32'h3d193b88;
        gap         = $urandom(seed);
        read_golden(ok);
        if (!ok) begin
            $display("golden file is missing or holds no records");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #1 rst = 1'b0;
            for (int i = 0; i < n_rec; i++) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                send_word(stim_word[i], stim_con[i]);
            end
            wait (dsp_ctrl_checker.checked >= n_rec);
            repeat (4) @(posedge clk);  // Let the last hold cycle pass
            dsp_ctrl_checker.report();
            if (dsp_ctrl_checker.errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

    // Watchdog sized from the record count
    initial begin
        wait (loaded);
        #((n_rec * CYCLES_PER_REC + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout at %0t ns, only %0d of %0d control words seen",
                 $time, dsp_ctrl_checker.checked, n_rec);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verif/dsp_ctrl_golden.txt
# test instr(hex) con branch(goto_ja goto_b call_ja) loads(short long ximm xacc dimm dacc
# ramld rmux ramwe dec accram sta0h sta1h) yaau rfield rsel double idx first last fault
1 0123 1 100 0000000000000 000000 0 0 1 0 0 0 0
2 0123 0 000 0000000000000 000000 0 0 1 0 0 0 0
3 8045 1 001 0000000000000 000000 0 0 1 0 0 0 0
4 8045 0 000 0000000000000 000000 0 0 1 0 0 0 0
5 C00A 1 010 0000000000000 000000 0 0 1 0 0 0 0
6 C00A 0 000 0000000000000 000000 0 0 1 0 0 0 0
7 12A5 0 000 1000000000000 000000 5 0 0 0 0 0 0
8 1A33 0 000 1000000000000 000000 1 0 0 0 0 0 0
9 5030 0 000 0100000000000 000000 3 0 1 0 0 0 0
10 50A0 0 000 0010000000000 000000 2 0 1 0 0 0 0
11 4940 0 000 0000010000000 000000 4 0 1 0 0 0 0
12 58B0 0 000 0001000000000 000000 3 0 1 0 0 0 0
13 7954 0 000 0000001000000 101001 5 5 1 0 0 0 0
14 60A9 0 000 0000000110000 110010 2 2 1 0 0 0 0
15 300E 0 000 0000000001000 100011 0 0 0 0 0 0 0
16 3803 0 000 0000000001101 100100 0 0 0 0 0 0 0
17 B001 0 000 0000001001000 110000 0 0 0 0 0 0 0
18 D005 0 000 0000000000000 000000 0 0 0 0 0 0 0
19 7182 0 000 0000000000000 000000 0 0 0 0 0 0 0
20 D000 0 000 0000000000000 000000 0 0 0 0 0 0 0
21 12A5 0 000 1000000000000 000000 5 0 0 1 0 0 0
22 300E 0 000 0000000001000 100011 0 0 0 2 1 0 0
23 4940 0 000 0000010000000 000000 4 0 1 0 0 0 0
24 D000 0 000 0000000000000 000000 0 0 0 1 0 0 0
25 B001 0 000 0000001001000 110000 0 0 0 2 0 1 0
26 1A33 0 000 1000000000000 000000 1 0 0 0 0 0 0
27 7101 0 000 0000000000000 000000 0 0 0 0 0 0 0
28 D000 0 000 0000000000000 000000 0 0 0 0 0 0 0
29 0123 1 100 0000000000000 000000 0 0 1 1 1 1 1
30 F800 0 000 0000000000000 000000 0 0 0 0 0 0 1
31 12A5 0 000 1000000000000 000000 5 0 0 0 0 0 1

// File: dsp_ctrl.f
verilog/dsp_ctrl_pkg.sv
verilog/issue_seq.sv
verilog/instr_decoder.sv
verilog/do_loop_ctr.sv
verilog/dsp_ctrl.sv
verif/dsp_ctrl_checker.sv
verif/dsp_ctrl_tb.sv
